//--- include/rv_cfg.svh
////////////////////////////////////////////////////////////
// core sizing, include wherever widths or reset PC are needed
////////////////////////////////////////////////////////////
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

`define RV_RESET_PC 32'h0000_0000 // first fetch address
`define RV_XLEN     32
`define RV_NREGS    32

`endif

//--- hw/rvPkg.sv
////////////////////////////////////////////////////////////
// shared types for the multicycle RV32I core
////////////////////////////////////////////////////////////
package rvPkg;

  typedef enum logic [4:0] {
    FETCH, FETCH_WAIT, DECODE, AUIPC, LUI, UNCONDJUMP,
    EXECUTER, EXECUTEI, MEMADR, MEMREAD, MEMWRITE, MEMWB,
    BRANCHIFEQ, BRANCHCOMP, ALUWB, JALR_CALC, JALR_STEP2,
    SPARE0, SPARE1
  } state_t;

  typedef enum logic [6:0] {
    RType      = 7'b0110011,
    ITypeLogic = 7'b0010011,
    ITypeLoad  = 7'b0000011,
    ITypeJalr  = 7'b1100111,
    SType      = 7'b0100011,
    BType      = 7'b1100011,
    UTypeLui   = 7'b0110111,
    UTypeAuipc = 7'b0010111,
    JType      = 7'b1101111,
    FENCE      = 7'b0001111
  } opcode_t;

  typedef enum logic       {ADR_PC, ADR_RESULT} adrSrc_t; // result mux feeds memAddr
  typedef enum logic [1:0] {PC_INCR, PC_JUMP, PC_ALU_RESULT} pcSrc_t;
  typedef enum logic [1:0] {SRCA_OLD_PC, SRCA_RS1, SRCA_ZERO} aluSrcA_t;
  typedef enum logic [1:0] {SRCB_RS2, SRCB_IMM, SRCB_FOUR} aluSrcB_t;
  typedef enum logic [1:0] {RES_ALU_OUT, RES_ALU_RESULT, RES_DATA} resultSrc_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SGE, ALU_SGEU
  } aluOp_t;

  // one instruction word, six ways to look at it
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
  } rFmt_t;
  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
  } iFmt_t;
  typedef struct packed {
    logic [6:0] immHi; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] immLo; logic [6:0] opcode;
  } sFmt_t;
  typedef struct packed {
    logic imm12; logic [5:0] imm10to5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4to1; logic imm11; logic [6:0] opcode;
  } bFmt_t;
  typedef struct packed {
    logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
  } uFmt_t;
  typedef struct packed {
    logic imm20; logic [9:0] imm10to1; logic imm11; logic [7:0] imm19to12;
    logic [4:0] rd; logic [6:0] opcode;
  } jFmt_t;

  typedef union packed {
    rFmt_t r;
    iFmt_t i;
    sFmt_t s;
    bFmt_t b;
    uFmt_t u;
    jFmt_t j;
  } instr_u;

endpackage

//--- hw/ctrlBus.sv
////////////////////////////////////////////////////////////
// per-state control strobes, FSM to datapath
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface ctrlBus;
  import rvPkg::*;

  adrSrc_t    adrSrc;
  logic       irWrite;
  logic       regWrite;
  logic       pcUpdate;
  pcSrc_t     pcSrc;
  logic [3:0] memWrite; // byte strobes
  aluSrcA_t   aluSrcA;
  aluSrcB_t   aluSrcB;
  resultSrc_t resultSrc;

  modport fsm (output adrSrc, irWrite, regWrite, pcUpdate, pcSrc, memWrite,
                      aluSrcA, aluSrcB, resultSrc);

  modport dp  (input  adrSrc, irWrite, regWrite, pcUpdate, pcSrc, memWrite,
                      aluSrcA, aluSrcB, resultSrc);

endinterface

//--- hw/controlFsm.sv
////////////////////////////////////////////////////////////
// Moore control FSM, sequences every instruction
// fetch, fetch wait, decode, then 1..3 work states
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module controlFsm (
  input  logic            clk,
  input  logic            reset,
  input  rvPkg::opcode_t  opcode,
  input  logic [2:0]      funct3,
  input  logic            zero,
  input  logic            aluBit0,
  input  logic [3:0]      byteMask,
  output rvPkg::state_t   state,
  ctrlBus.fsm             ctrl
);
  import rvPkg::*;

  state_t nextState;

  always_ff @(posedge clk) begin
    if (reset) state <= FETCH;
    else       state <= nextState;
  end

  always_comb begin
    case (state)
      FETCH:      nextState = FETCH_WAIT;
      FETCH_WAIT: nextState = DECODE;
      DECODE: begin
        case (opcode)
          JType:      nextState = UNCONDJUMP;
          RType:      nextState = EXECUTER;
          ITypeLogic: nextState = EXECUTEI;
          ITypeLoad,
          SType:      nextState = MEMADR;
          BType:      nextState = (funct3[2:1] == 2'b00) ? BRANCHIFEQ : BRANCHCOMP;
          UTypeAuipc: nextState = AUIPC;
          UTypeLui:   nextState = LUI;
          ITypeJalr:  nextState = JALR_CALC;
          FENCE:      nextState = FETCH;
          default:    nextState = DECODE; // unknown opcode hangs here
        endcase
      end
      AUIPC, LUI, UNCONDJUMP,
      EXECUTER, EXECUTEI:  nextState = ALUWB;
      MEMADR:     nextState = (opcode == SType) ? MEMWRITE : MEMREAD;
      MEMREAD:    nextState = MEMWB;
      JALR_CALC:  nextState = JALR_STEP2;
      JALR_STEP2: nextState = ALUWB;
      default:    nextState = FETCH; // writebacks, branches, stores, spares
    endcase
  end

  always_comb begin
    ctrl.adrSrc    = ADR_PC;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.pcSrc     = PC_INCR;
    ctrl.memWrite  = 4'b0000;
    ctrl.aluSrcA   = SRCA_OLD_PC;
    ctrl.aluSrcB   = SRCB_FOUR;
    ctrl.resultSrc = RES_ALU_OUT;

    case (state)
      FETCH_WAIT: begin // instruction word is on memRData now
        ctrl.irWrite  = 1'b1;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = PC_INCR;
      end
      DECODE, AUIPC: begin // branch/jump target or auipc sum
        ctrl.aluSrcA = SRCA_OLD_PC;
        ctrl.aluSrcB = SRCB_IMM;
      end
      LUI: begin
        ctrl.aluSrcA = SRCA_ZERO;
        ctrl.aluSrcB = SRCB_IMM;
      end
      EXECUTER: begin
        ctrl.aluSrcA = SRCA_RS1;
        ctrl.aluSrcB = SRCB_RS2;
      end
      EXECUTEI: begin
        ctrl.aluSrcA = SRCA_RS1;
        ctrl.aluSrcB = SRCB_IMM;
      end
      UNCONDJUMP: begin
        ctrl.aluSrcA  = SRCA_OLD_PC; // link value
        ctrl.aluSrcB  = SRCB_FOUR;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = PC_JUMP;     // target from decode
      end
      JALR_CALC: begin
        ctrl.aluSrcA  = SRCA_RS1;
        ctrl.aluSrcB  = SRCB_IMM;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = PC_ALU_RESULT; // rs1 + imm, bit 0 dropped
      end
      JALR_STEP2: begin
        ctrl.aluSrcA = SRCA_OLD_PC;
        ctrl.aluSrcB = SRCB_FOUR;
      end
      MEMADR: begin
        ctrl.aluSrcA   = SRCA_RS1;
        ctrl.aluSrcB   = SRCB_IMM;
        ctrl.adrSrc    = ADR_RESULT;
        ctrl.resultSrc = RES_ALU_RESULT; // live address
      end
      MEMREAD: begin
        ctrl.adrSrc = ADR_RESULT;
      end
      MEMWRITE: begin
        ctrl.adrSrc   = ADR_RESULT;
        ctrl.memWrite = byteMask;
      end
      MEMWB: begin
        ctrl.resultSrc = RES_DATA;
        ctrl.regWrite  = 1'b1;
      end
      ALUWB: ctrl.regWrite = 1'b1;
      BRANCHIFEQ: begin
        ctrl.aluSrcA  = SRCA_RS1;
        ctrl.aluSrcB  = SRCB_RS2;
        ctrl.pcSrc    = PC_JUMP;
        ctrl.pcUpdate = zero ^ funct3[0]; // beq on zero, bne otherwise
      end
      BRANCHCOMP: begin
        ctrl.aluSrcA  = SRCA_RS1;
        ctrl.aluSrcB  = SRCB_RS2;
        ctrl.pcSrc    = PC_JUMP;
        ctrl.pcUpdate = aluBit0; // compare already has the right sense
      end
      default: ;
    endcase
  end

endmodule

//--- hw/aluControl.sv
////////////////////////////////////////////////////////////
// picks the ALU operation from state and instruction fields
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module aluControl (
  input  rvPkg::opcode_t opcode,
  input  logic [2:0]     funct3,
  input  logic [6:0]     funct7,
  input  rvPkg::state_t  state,
  output rvPkg::aluOp_t  aluOp
);
  import rvPkg::*;

  always_comb begin
    case (state)
      BRANCHIFEQ: aluOp = ALU_SUB;
      BRANCHCOMP: begin
        case (funct3)
          3'b100:  aluOp = ALU_SLT;  // blt
          3'b101:  aluOp = ALU_SGE;  // bge
          3'b110:  aluOp = ALU_SLTU;
          default: aluOp = ALU_SGEU;
        endcase
      end
      EXECUTER, EXECUTEI: begin
        case (funct3)
          3'b000:  aluOp = (opcode == RType && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  aluOp = ALU_SLL;
          3'b010:  aluOp = ALU_SLT;
          3'b011:  aluOp = ALU_SLTU;
          3'b100:  aluOp = ALU_XOR;
          3'b101:  aluOp = funct7[5] ? ALU_SRA : ALU_SRL; // srai keeps bit 30 too
          3'b110:  aluOp = ALU_OR;
          default: aluOp = ALU_AND;
        endcase
      end
      // addresses, link values and targets are all sums
      default: aluOp = ALU_ADD;
    endcase
  end

endmodule

//--- hw/datapath.sv
////////////////////////////////////////////////////////////
// PC, IR, register file, ALU and the memory-side muxes
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "rv_cfg.svh"

module datapath (
  input  logic                 clk,
  input  logic                 reset,
  ctrlBus.dp                   ctrl,
  input  rvPkg::aluOp_t        aluOp,
  input  logic [`RV_XLEN-1:0]  memRData,
  output logic [`RV_XLEN-1:0]  memAddr,
  output logic [`RV_XLEN-1:0]  memWData,
  output rvPkg::opcode_t       opcode,
  output logic [2:0]           funct3,
  output logic [6:0]           funct7,
  output logic                 zero,
  output logic                 aluBit0,
  output logic [3:0]           byteMask
);
  import rvPkg::*;

  logic [`RV_XLEN-1:0] pc, oldPc, pcNext;
  instr_u              ir;
  logic [`RV_XLEN-1:0] regs [`RV_NREGS];
  logic [`RV_XLEN-1:0] rs1Val, rs2Val, immExt;
  logic [`RV_XLEN-1:0] srcA, srcB, aluResult, aluOut, dataReg, result;
  logic [1:0]          byteOff;

  assign opcode = opcode_t'(ir.r.opcode);
  assign funct3 = ir.r.funct3;
  assign funct7 = ir.r.funct7;

  always_ff @(posedge clk) begin
    if (reset)              pc <= `RV_RESET_PC;
    else if (ctrl.pcUpdate) pc <= pcNext;
  end

  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      ir    <= memRData;
      oldPc <= pc; // fetch address of this instruction
    end
    aluOut  <= aluResult;
    dataReg <= memRData;
    if (ctrl.regWrite && ir.r.rd != 5'd0) regs[ir.r.rd] <= result;
  end

  assign rs1Val = (ir.r.rs1 == 5'd0) ? '0 : regs[ir.r.rs1];
  assign rs2Val = (ir.r.rs2 == 5'd0) ? '0 : regs[ir.r.rs2];

  always_comb begin
    case (opcode)
      ITypeLogic, ITypeLoad, ITypeJalr: immExt = {{20{ir.i.imm[11]}}, ir.i.imm};
      SType:   immExt = {{20{ir.s.immHi[6]}}, ir.s.immHi, ir.s.immLo};
      BType:   immExt = {{20{ir.b.imm12}}, ir.b.imm11, ir.b.imm10to5, ir.b.imm4to1, 1'b0};
      UTypeLui, UTypeAuipc: immExt = {ir.u.imm, 12'h000};
      JType:   immExt = {{12{ir.j.imm20}}, ir.j.imm19to12, ir.j.imm11, ir.j.imm10to1, 1'b0};
      default: immExt = '0;
    endcase
  end

  always_comb begin
    case (ctrl.aluSrcA)
      SRCA_RS1:  srcA = rs1Val;
      SRCA_ZERO: srcA = '0;
      default:   srcA = oldPc;
    endcase
    case (ctrl.aluSrcB)
      SRCB_RS2: srcB = rs2Val;
      SRCB_IMM: srcB = immExt;
      default:  srcB = `RV_XLEN'd4;
    endcase
  end

  always_comb begin
    case (aluOp)
      ALU_SUB:  aluResult = srcA - srcB;
      ALU_SLL:  aluResult = srcA << srcB[4:0];
      ALU_SRL:  aluResult = srcA >> srcB[4:0];
      ALU_SRA:  aluResult = $signed(srcA) >>> srcB[4:0];
      ALU_AND:  aluResult = srcA & srcB;
      ALU_OR:   aluResult = srcA | srcB;
      ALU_XOR:  aluResult = srcA ^ srcB;
      ALU_SLT:  aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
      ALU_SLTU: aluResult = {31'd0, srcA < srcB};
      ALU_SGE:  aluResult = {31'd0, $signed(srcA) >= $signed(srcB)};
      ALU_SGEU: aluResult = {31'd0, srcA >= srcB};
      default:  aluResult = srcA + srcB;
    endcase
  end

  assign zero    = (aluResult == '0);
  assign aluBit0 = aluResult[0];

  always_comb begin
    case (ctrl.resultSrc)
      RES_ALU_RESULT: result = aluResult;
      RES_DATA:       result = dataReg;
      default:        result = aluOut;
    endcase
    case (ctrl.pcSrc)
      PC_JUMP:       pcNext = aluOut;
      PC_ALU_RESULT: pcNext = {aluResult[`RV_XLEN-1:1], 1'b0};
      default:       pcNext = pc + `RV_XLEN'd4;
    endcase
  end

  assign memAddr = (ctrl.adrSrc == ADR_RESULT) ? result : pc;

  // store lanes follow the low address bits
  assign byteOff  = memAddr[1:0];
  assign memWData = rs2Val << {byteOff, 3'b000};

  always_comb begin
    case (funct3[1:0])
      2'b00:   byteMask = 4'b0001 << byteOff; // sb
      2'b01:   byteMask = byteOff[1] ? 4'b1100 : 4'b0011;
      default: byteMask = 4'b1111;
    endcase
  end

endmodule

//--- hw/rvCore.sv
////////////////////////////////////////////////////////////
// core top level, plain single-port memory interface
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvCore (
  input  logic                clk,
  input  logic                reset,
  input  logic [`RV_XLEN-1:0] memRData,
  output logic [`RV_XLEN-1:0] memAddr,
  output logic [`RV_XLEN-1:0] memWData,
  output logic [3:0]          memWStrb,
  output rvPkg::state_t       fsmState
);
  import rvPkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       zero, aluBit0;
  logic [3:0] byteMask;
  aluOp_t     aluOp;

  ctrlBus bus ();

  controlFsm i_controlFsm (
    .clk, .reset, .opcode, .funct3, .zero, .aluBit0, .byteMask,
    .state (fsmState),
    .ctrl  (bus.fsm)
  );

  aluControl i_aluControl (
    .opcode, .funct3, .funct7,
    .state (fsmState),
    .aluOp
  );

  datapath i_datapath (
    .clk, .reset,
    .ctrl (bus.dp),
    .aluOp, .memRData, .memAddr, .memWData,
    .opcode, .funct3, .funct7, .zero, .aluBit0, .byteMask
  );

  assign memWStrb = bus.memWrite;

endmodule

//--- bench/rvCoreTb_assert.sv
////////////////////////////////////////////////////////////
// port assertions bound into every rvCore instance
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvCoreTb_assert (
  input logic                clk,
  input logic                reset,
  input logic [`RV_XLEN-1:0] memAddr,
  input logic [3:0]          memWStrb,
  input rvPkg::state_t       fsmState
);
  import rvPkg::*;

  int unsigned failCount = 0;

  // first cycle out of reset is the fetch of the reset PC
  resetExit: assert property (@(posedge clk) $fell(reset) |->
      (fsmState == FETCH && memAddr == `RV_RESET_PC && memWStrb == 4'b0000))
    else begin
      failCount++;
      $error("core not at the first fetch after reset");
    end

  quietInReset: assert property (@(posedge clk) reset |-> memWStrb == 4'b0000)
    else begin
      failCount++;
      $error("write strobe active during reset");
    end

  strobeState: assert property (@(posedge clk) disable iff (reset)
      memWStrb != 4'b0000 |-> fsmState == MEMWRITE)
    else begin
      failCount++;
      $error("write strobe outside MEMWRITE");
    end

  strobeOneCycle: assert property (@(posedge clk) disable iff (reset)
      memWStrb != 4'b0000 |=> memWStrb == 4'b0000)
    else begin
      failCount++;
      $error("write strobe held for more than one cycle");
    end

endmodule

bind rvCore rvCoreTb_assert coreChecks (.clk, .reset, .memAddr, .memWStrb, .fsmState);

//--- bench/rvCoreTb.sv
////////////////////////////////////////////////////////////
// runs a hand-assembled RV32I program on rvCore and checks every
// result store against a table until the done marker is stored
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "rv_cfg.svh"

module rvCoreTb;
  import rvPkg::*;

  localparam int unsigned numInstr   = 60;
  localparam int unsigned timeoutNs  = (8 + numInstr * 6 * 2) * 40;
  localparam logic [31:0] resultBase = 32'h0000_0100;
  localparam logic [31:0] doneAddr   = 32'h0000_01FC;
  localparam logic [6:0]  opImm      = 7'b0010011;
  localparam logic [6:0]  opLoad     = 7'b0000011;
  localparam logic [6:0]  opJalr     = 7'b1100111;
  localparam logic [6:0]  opLui      = 7'b0110111;
  localparam logic [6:0]  opAuipc    = 7'b0010111;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic [`RV_XLEN-1:0] memRData = '0;
  logic [`RV_XLEN-1:0] memAddr;
  logic [`RV_XLEN-1:0] memWData;
  logic [3:0]          memWStrb;
  state_t              fsmState;

  logic [31:0] mem [256];
  logic [31:0] expAddr[$];
  logic [31:0] expData[$]; // strobed lanes only
  logic [3:0]  expStrb[$];

  rvCore i_rvCore (.clk, .reset, .memRData, .memAddr, .memWData, .memWStrb, .fsmState);

  // instruction encoders with operands in assembly order
  function automatic logic [31:0] rType(input int f7, input int f3, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] iType(input logic [6:0] op, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] sType(input int f3, input int rs2, input int rs1,
                                        input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] bType(input int f3, input int rs1, input int rs2,
                                        input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] uType(input logic [6:0] op, input int rd, input int imm);
    return {imm[19:0], rd[4:0], op};
  endfunction

  function automatic logic [31:0] jType(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic [31:0] laneMask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    expAddr.push_back(addr);
    expData.push_back(data);
    expStrb.push_back(strb);
  endtask

  task automatic stopWithFailure();
    $display("Test FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    $display("Fail %0t %s expected %h got %h", $time, sigName, expVal, gotVal);
    stopWithFailure();
  endtask

  always #20 clk = ~clk;

  initial begin
    repeat (8) @(posedge clk);
    #2 reset = 1'b0;
  end

  initial begin
    for (int w = 0; w < 256; w++) mem[w] = '0;
    mem[0]  = iType(opImm, 0, 10, 0, 256);        // x10 = result area
    mem[1]  = uType(opLui, 1, 20'h12345);
    mem[2]  = sType(2, 1, 10, 0);
    mem[3]  = iType(opImm, 0, 2, 0, 100);
    mem[4]  = iType(opImm, 0, 3, 0, -7);
    mem[5]  = rType(7'h00, 0, 4, 2, 3);           // add
    mem[6]  = sType(2, 4, 10, 4);
    mem[7]  = rType(7'h20, 0, 5, 2, 3);           // sub
    mem[8]  = sType(2, 5, 10, 8);
    mem[9]  = iType(opImm, 5, 6, 3, 12'h401);     // srai x6, x3, 1
    mem[10] = rType(7'h00, 4, 6, 6, 1);           // xor
    mem[11] = sType(2, 6, 10, 12);
    mem[12] = rType(7'h00, 2, 7, 3, 2);           // slt
    mem[13] = rType(7'h00, 3, 8, 3, 2);           // sltu
    mem[14] = iType(opImm, 1, 7, 7, 4);           // slli
    mem[15] = rType(7'h00, 0, 7, 7, 8);
    mem[16] = iType(opImm, 5, 9, 3, 28);          // srli
    mem[17] = rType(7'h00, 6, 7, 7, 9);           // or
    mem[18] = iType(opImm, 7, 7, 7, 12'h01C);     // andi
    mem[19] = sType(2, 7, 10, 16);
    mem[20] = uType(opAuipc, 11, 20'h00001);
    mem[21] = sType(2, 11, 10, 20);
    // each branch type runs not taken and then taken over an error store
    mem[22] = bType(0, 2, 3, 8);
    mem[23] = bType(0, 2, 2, 8);
    mem[25] = bType(1, 2, 2, 8);
    mem[26] = bType(1, 2, 3, 8);
    mem[28] = bType(4, 2, 3, 8);
    mem[29] = bType(4, 3, 2, 8);
    mem[31] = bType(5, 3, 2, 8);
    mem[32] = bType(5, 2, 3, 8);
    mem[34] = bType(6, 3, 2, 8);
    mem[35] = bType(6, 2, 3, 8);
    mem[37] = bType(7, 2, 3, 8);
    mem[38] = bType(7, 3, 2, 8);
    for (int e = 24; e <= 39; e += 3) mem[e] = sType(2, 3, 10, 12'h0F0);
    mem[40] = sType(2, 2, 10, 24);
    mem[41] = jType(14, 8);
    mem[42] = sType(2, 3, 10, 12'h0F0);
    mem[43] = sType(2, 14, 10, 28);
    mem[44] = iType(opImm, 0, 15, 0, 12'h0BD);    // odd target
    mem[45] = iType(opJalr, 0, 16, 15, 0);
    mem[46] = sType(2, 3, 10, 12'h0F0);
    mem[47] = sType(2, 16, 10, 32);
    mem[48] = sType(0, 2, 10, 36);                // sb to each lane
    mem[49] = sType(0, 3, 10, 37);
    mem[50] = sType(0, 4, 10, 38);
    mem[51] = sType(0, 5, 10, 39);
    mem[52] = iType(opLoad, 2, 18, 10, 36);
    mem[53] = sType(2, 18, 10, 40);
    mem[54] = sType(1, 3, 10, 44);                // sh low, then high
    mem[55] = sType(1, 1, 10, 46);
    mem[56] = iType(opLoad, 2, 19, 10, 44);
    mem[57] = sType(2, 19, 10, 48);
    mem[58] = sType(2, 4, 10, 12'h0FC);           // done marker
    mem[59] = jType(0, 0);

    expectStore(32'h100, 32'h1234_5000, 4'hF);
    expectStore(32'h104, 32'h0000_005D, 4'hF);
    expectStore(32'h108, 32'h0000_006B, 4'hF);
    expectStore(32'h10C, 32'hEDCB_AFFC, 4'hF);
    expectStore(32'h110, 32'h0000_001C, 4'hF);
    expectStore(32'h114, 32'h0000_1050, 4'hF);
    expectStore(32'h118, 32'h0000_0064, 4'hF);
    expectStore(32'h11C, 32'h0000_00A8, 4'hF);    // jal link
    expectStore(32'h120, 32'h0000_00B8, 4'hF);    // jalr link
    expectStore(32'h124, 32'h0000_0064, 4'h1);
    expectStore(32'h125, 32'h0000_F900, 4'h2);
    expectStore(32'h126, 32'h005D_0000, 4'h4);
    expectStore(32'h127, 32'h6B00_0000, 4'h8);
    expectStore(32'h128, 32'h6B5D_F964, 4'hF);
    expectStore(32'h12C, 32'h0000_FFF9, 4'h3);
    expectStore(32'h12E, 32'h5000_0000, 4'hC);
    expectStore(32'h130, 32'h5000_FFF9, 4'hF);
  end

  // single-port memory with one cycle of read latency
  always @(posedge clk) begin : memModel
    logic [31:0] rdWord;
    for (int b = 0; b < 4; b++) begin
      if (memWStrb[b]) mem[memAddr[9:2]][8*b +: 8] = memWData[8*b +: 8];
    end
    rdWord = mem[memAddr[9:2]];
    #2 memRData = rdWord;
  end

  task automatic checkStore();
    if (memAddr == doneAddr) begin
      if (expAddr.size() == 0) begin
        $display("Test OK");
        $finish;
      end else begin
        $display("done marker stored with %0d result stores missing", expAddr.size());
        stopWithFailure();
      end
    end else if (expAddr.size() == 0) begin
      $display("unexpected store to %h at %0t", memAddr, $time);
      stopWithFailure();
    end else begin
      assert (memAddr == expAddr[0]) begin
        assert (memWStrb == expStrb[0]) begin
          assert ((memWData & laneMask(memWStrb)) == expData[0]) begin
            void'(expAddr.pop_front());
            void'(expData.pop_front());
            void'(expStrb.pop_front());
          end else begin
            reportMismatch("memWData", expData[0], memWData & laneMask(memWStrb));
          end
        end else begin
          reportMismatch("memWStrb", 32'(expStrb[0]), 32'(memWStrb));
        end
      end else begin
        reportMismatch("memAddr", expAddr[0], memAddr);
      end
    end
  endtask

  always @(posedge clk) begin : storeChecker
    if (memWStrb != 4'b0000 && memAddr >= resultBase) checkStore();
  end

  always @(i_rvCore.coreChecks.failCount) begin : assertWatcher
    if (i_rvCore.coreChecks.failCount != 0) begin
      $display("a port assertion on the core failed at %0t", $time);
      stopWithFailure();
    end
  end

  initial begin : watchdog
    #(timeoutNs);
    $display("program did not finish within %0d ns", timeoutNs);
    stopWithFailure();
  end

endmodule

//--- build.f
+incdir+include
hw/rvPkg.sv
hw/ctrlBus.sv
hw/controlFsm.sv
hw/aluControl.sv
hw/datapath.sv
hw/rvCore.sv
bench/rvCoreTb_assert.sv
bench/rvCoreTb.sv
